/* Makefile */
VERILATOR ?= verilator
TOP       := tb_exu
FILELIST  := vlog.f
VFLAGS    := --binary --timing --assert -Wno-fatal
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* exu_arith.sv */
//**********************************************************************
// add/sub, set-less-than, overflow and leading zero/one count
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module exu_arith
  import exu_pkg::*;
(
  input  wire logic [OP_W-1:0] op_i,
  input  wire logic [XLEN-1:0] a_i,
  input  wire logic [XLEN-1:0] b_i,
  output logic      [XLEN-1:0] res_o,
  output logic                 ovf_o
);

  logic            is_sub;
  logic [XLEN-1:0] b_mux;
  logic [XLEN-1:0] sum;
  logic            eff_b_sign;
  logic            lt_signed;
  logic            lt_unsigned;
  logic [XLEN-1:0] clz_in;
  logic [5:0]      clz_cnt;

  function automatic logic [5:0] lead_zeros(input logic [XLEN-1:0] x);
    logic [5:0] cnt;
    logic       found;
    cnt   = 6'd32;
    found = 1'b0;
    for (int i = XLEN - 1; i >= 0; i--)
    begin
      if (!found && x[i])
      begin
        cnt   = 6'(XLEN - 1 - i);
        found = 1'b1;
      end
    end
    return cnt;
  endfunction

  // one adder, b negated for subtract and signed compare
  assign is_sub = (op_i == OP_SUB) || (op_i == OP_SUBU) || (op_i == OP_SLT);
  assign b_mux  = is_sub ? (~b_i + 1'b1) : b_i;
  assign sum    = a_i + b_mux;

  // sign of the true second operand, safe for b = most negative
  assign eff_b_sign = is_sub ? ~b_i[XLEN-1] : b_i[XLEN-1];
  assign ovf_o      = ((op_i == OP_ADD) || (op_i == OP_SUB)) &&
                      (a_i[XLEN-1] == eff_b_sign) && (sum[XLEN-1] != a_i[XLEN-1]);

  // differing signs decide directly, else the difference sign
  assign lt_signed   = (a_i[XLEN-1] && !b_i[XLEN-1]) ||
                       ((a_i[XLEN-1] == b_i[XLEN-1]) && sum[XLEN-1]);
  assign lt_unsigned = a_i < b_i;

  // clo counts zeros of the inverted word
  assign clz_in  = (op_i == OP_CLO) ? ~a_i : a_i;
  assign clz_cnt = lead_zeros(clz_in);

  always_comb
  begin
    case (op_i)
      OP_ADD, OP_ADDU, OP_SUB, OP_SUBU:
        res_o = sum;
      OP_SLT:
        res_o = {{(XLEN-1){1'b0}}, lt_signed};
      OP_SLTU:
        res_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      OP_CLZ, OP_CLO:
        res_o = {{(XLEN-6){1'b0}}, clz_cnt};
      default:
        res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* exu_hilo.sv */
//**********************************************************************
// hi/lo register pair, written by the multiplier or by mthi/mtlo
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module exu_hilo
  import exu_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            reset_i,
  input  wire logic            accept_i,
  input  wire logic [OP_W-1:0] op_i,
  input  wire logic [XLEN-1:0] a_i,
  input  wire logic            mul_we_i,
  input  wire hilo_u           mul_hilo_i,
  output hilo_u                hilo_o
);

  hilo_u hilo_q;

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      hilo_q.dw <= '0;
    end
    else if (mul_we_i)
    begin
      hilo_q <= mul_hilo_i;
    end
    else if (accept_i && (op_i == OP_MTHI))
    begin
      hilo_q.hl.hi <= a_i;
    end
    else if (accept_i && (op_i == OP_MTLO))
    begin
      hilo_q.hl.lo <= a_i;
    end
  end

  assign hilo_o = hilo_q;

endmodule

`default_nettype wire

/* exu_logic_shift.sv */
//**********************************************************************
// logical and shift results, purely combinational
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module exu_logic_shift
  import exu_pkg::*;
(
  input  wire logic [OP_W-1:0] op_i,
  input  wire logic [XLEN-1:0] a_i,
  input  wire logic [XLEN-1:0] b_i,
  output logic      [XLEN-1:0] res_o
);

  logic [4:0] shamt;

  // shift amount from the low bits of a
  assign shamt = a_i[4:0];

  always_comb
  begin
    case (op_i)
      OP_OR:
        res_o = a_i | b_i;
      OP_AND:
        res_o = a_i & b_i;
      OP_XOR:
        res_o = a_i ^ b_i;
      OP_NOR:
        res_o = ~(a_i | b_i);
      OP_SLL:
        res_o = b_i << shamt;
      OP_SRL:
        res_o = b_i >> shamt;
      // sign fill from b
      OP_SRA:
        res_o = $signed(b_i) >>> shamt;
      default:
        res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* exu_mul.sv */
//**********************************************************************
// multiplier with madd/msub accumulate step and the input handshake
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module exu_mul
  import exu_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            reset_i,
  input  wire logic            op_valid_i,
  input  wire logic [OP_W-1:0] op_i,
  input  wire logic [XLEN-1:0] a_i,
  input  wire logic [XLEN-1:0] b_i,
  input  wire hilo_u           hilo_i,
  output logic                 op_ready_o,
  output logic                 accept_o,
  output logic      [XLEN-1:0] mul_lo_o,
  output logic                 hilo_we_o,
  output hilo_u                hilo_o
);

  logic              signed_op;
  logic              is_acc;
  logic              is_msub;
  logic              is_mult;
  logic [XLEN-1:0]   a_mag;
  logic [XLEN-1:0]   b_mag;
  logic [2*XLEN-1:0] prod_mag;
  logic [2*XLEN-1:0] prod;
  logic [2*XLEN-1:0] acc_d;
  logic [2*XLEN-1:0] acc_q;
  logic              acc_pend_q;
  logic              ready_q;

  //********************************************************************
  // product from magnitudes
  //********************************************************************
  assign signed_op = (op_i == OP_MULT) || (op_i == OP_MUL) ||
                     (op_i == OP_MADD) || (op_i == OP_MSUB);
  assign is_acc    = (op_i == OP_MADD) || (op_i == OP_MADDU) ||
                     (op_i == OP_MSUB) || (op_i == OP_MSUBU);
  assign is_msub   = (op_i == OP_MSUB) || (op_i == OP_MSUBU);
  // mul also refreshes hi/lo with the full product
  assign is_mult   = (op_i == OP_MULT) || (op_i == OP_MULTU) || (op_i == OP_MUL);

  assign a_mag    = (signed_op && a_i[XLEN-1]) ? (~a_i + 1'b1) : a_i;
  assign b_mag    = (signed_op && b_i[XLEN-1]) ? (~b_i + 1'b1) : b_i;
  assign prod_mag = a_mag * b_mag;
  assign prod     = (signed_op && (a_i[XLEN-1] ^ b_i[XLEN-1])) ? (~prod_mag + 1'b1)
                                                               : prod_mag;
  assign mul_lo_o = prod[XLEN-1:0];

  // msub accumulates the negated product
  assign acc_d = is_msub ? (~prod + 1'b1) : prod;

  //********************************************************************
  // handshake and accumulate state
  //********************************************************************
  assign op_ready_o = ready_q;
  assign accept_o   = op_valid_i && ready_q;

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      ready_q    <= 1'b0;
      acc_pend_q <= 1'b0;
    end
    else
    begin
      // one dead cycle after each accumulate op
      ready_q    <= !(accept_o && is_acc);
      acc_pend_q <= accept_o && is_acc;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept_o && is_acc)
    begin
      acc_q <= acc_d;
    end
  end

  // accumulate step has priority, no acceptance can overlap it
  assign hilo_we_o = acc_pend_q || (accept_o && is_mult);
  assign hilo_o.dw = acc_pend_q ? (hilo_i.dw + acc_q) : prod;

endmodule

`default_nettype wire

/* exu_pkg.sv */
//**********************************************************************
// shared widths, operation codes and result classes of the execute unit
// imported by every module of the unit and by the testbench
//**********************************************************************
`default_nettype none

package exu_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;
  localparam int OP_W   = 6;

  //********************************************************************
  // operation codes
  //********************************************************************
  localparam logic [OP_W-1:0] OP_OR    = 6'h00;
  localparam logic [OP_W-1:0] OP_AND   = 6'h01;
  localparam logic [OP_W-1:0] OP_XOR   = 6'h02;
  localparam logic [OP_W-1:0] OP_NOR   = 6'h03;
  localparam logic [OP_W-1:0] OP_SLL   = 6'h04;
  localparam logic [OP_W-1:0] OP_SRL   = 6'h05;
  localparam logic [OP_W-1:0] OP_SRA   = 6'h06;
  localparam logic [OP_W-1:0] OP_ADD   = 6'h08;
  localparam logic [OP_W-1:0] OP_ADDU  = 6'h09;
  localparam logic [OP_W-1:0] OP_SUB   = 6'h0a;
  localparam logic [OP_W-1:0] OP_SUBU  = 6'h0b;
  localparam logic [OP_W-1:0] OP_SLT   = 6'h0c;
  localparam logic [OP_W-1:0] OP_SLTU  = 6'h0d;
  localparam logic [OP_W-1:0] OP_CLZ   = 6'h0e;
  localparam logic [OP_W-1:0] OP_CLO   = 6'h0f;
  localparam logic [OP_W-1:0] OP_MULT  = 6'h10;
  localparam logic [OP_W-1:0] OP_MULTU = 6'h11;
  localparam logic [OP_W-1:0] OP_MUL   = 6'h12;
  localparam logic [OP_W-1:0] OP_MADD  = 6'h14;
  localparam logic [OP_W-1:0] OP_MADDU = 6'h15;
  localparam logic [OP_W-1:0] OP_MSUB  = 6'h16;
  localparam logic [OP_W-1:0] OP_MSUBU = 6'h17;
  localparam logic [OP_W-1:0] OP_MFHI  = 6'h18;
  localparam logic [OP_W-1:0] OP_MFLO  = 6'h19;
  localparam logic [OP_W-1:0] OP_MTHI  = 6'h1a;
  localparam logic [OP_W-1:0] OP_MTLO  = 6'h1b;

  // hi/lo pair as one double word or as two words
  typedef union packed {
    logic [2*XLEN-1:0] dw;
    struct packed {
      logic [XLEN-1:0] hi;
      logic [XLEN-1:0] lo;
    } hl;
  } hilo_u;

  // which result feeds the writeback data
  typedef enum logic [2:0] {
    CLS_NONE  = 3'd0,
    CLS_LOGIC = 3'd1,
    CLS_SHIFT = 3'd2,
    CLS_ARITH = 3'd3,
    CLS_MUL   = 3'd4,
    CLS_MOVE  = 3'd5
  } op_class_e;

  function automatic op_class_e op_class(input logic [OP_W-1:0] op);
    case (op)
      OP_OR, OP_AND, OP_XOR, OP_NOR:
        return CLS_LOGIC;
      OP_SLL, OP_SRL, OP_SRA:
        return CLS_SHIFT;
      OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO:
        return CLS_ARITH;
      OP_MUL:
        return CLS_MUL;
      OP_MFHI, OP_MFLO:
        return CLS_MOVE;
      // mult, madd and mt* only touch hi/lo
      default:
        return CLS_NONE;
    endcase
  endfunction

endpackage

`default_nettype wire

/* exu_sva.sv */
//**********************************************************************
// handshake and writeback timing properties, bound into exu_top
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module exu_sva
  import exu_pkg::*;
(
  input wire logic            clk,
  input wire logic            reset_i,
  input wire logic            op_valid_i,
  input wire logic [OP_W-1:0] op_i,
  input wire logic            op_ready_o,
  input wire logic            wb_valid_o,
  input wire logic            wb_we_o,
  input wire logic            ovf_o
);

  logic accept;
  logic acc_op;

  assign accept = op_valid_i && op_ready_o;
  assign acc_op = (op_i == OP_MADD) || (op_i == OP_MADDU) ||
                  (op_i == OP_MSUB) || (op_i == OP_MSUBU);

  // writeback exactly one cycle after acceptance
  wb_after_accept: assert property (@(posedge clk) disable iff (reset_i)
    accept |=> wb_valid_o) else $error("accepted operation gave no writeback");
  no_wb_without_accept: assert property (@(posedge clk) disable iff (reset_i)
    !accept |=> !wb_valid_o) else $error("writeback without an accepted operation");

  // one dead cycle after madd/msub
  acc_stall: assert property (@(posedge clk) disable iff (reset_i)
    (accept && acc_op) |=> !op_ready_o ##1 op_ready_o)
    else $error("accumulate stall is not exactly one cycle");

  we_clean: assert property (@(posedge clk) disable iff (reset_i)
    wb_we_o |-> (wb_valid_o && !ovf_o)) else $error("register write on overflow or idle");
  ovf_valid: assert property (@(posedge clk) disable iff (reset_i)
    ovf_o |-> wb_valid_o) else $error("overflow flag without a writeback");

endmodule

bind exu_top exu_sva sva_i (
  .clk        (clk),
  .reset_i    (reset_i),
  .op_valid_i (op_valid_i),
  .op_i       (op_i),
  .op_ready_o (op_ready_o),
  .wb_valid_o (wb_valid_o),
  .wb_we_o    (wb_we_o),
  .ovf_o      (ovf_o)
);

`default_nettype wire

/* exu_top.sv */
//**********************************************************************
// execute unit top, one op per cycle in, writeback one cycle later
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module exu_top
  import exu_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              reset_i,
  input  wire logic              op_valid_i,
  input  wire logic [OP_W-1:0]   op_i,
  input  wire logic [XLEN-1:0]   rs_data_i,
  input  wire logic [XLEN-1:0]   rt_data_i,
  input  wire logic [REG_AW-1:0] rd_addr_i,
  input  wire logic              rd_we_i,
  output logic                   op_ready_o,
  output logic                   wb_valid_o,
  output logic                   wb_we_o,
  output logic      [REG_AW-1:0] wb_addr_o,
  output logic      [XLEN-1:0]   wb_data_o,
  output logic                   ovf_o,
  output logic      [XLEN-1:0]   hi_o,
  output logic      [XLEN-1:0]   lo_o
);

  logic [XLEN-1:0] logic_res;
  logic [XLEN-1:0] arith_res;
  logic            arith_ovf;
  logic [XLEN-1:0] mul_lo;
  logic            accept;
  logic            mul_hilo_we;
  hilo_u           mul_hilo;
  hilo_u           hilo;

  exu_logic_shift logic_shift_i (
    .op_i  (op_i),
    .a_i   (rs_data_i),
    .b_i   (rt_data_i),
    .res_o (logic_res)
  );

  exu_arith arith_i (
    .op_i  (op_i),
    .a_i   (rs_data_i),
    .b_i   (rt_data_i),
    .res_o (arith_res),
    .ovf_o (arith_ovf)
  );

  // owns the handshake, acceptance is fanned out from here
  exu_mul mul_i (
    .clk        (clk),
    .reset_i    (reset_i),
    .op_valid_i (op_valid_i),
    .op_i       (op_i),
    .a_i        (rs_data_i),
    .b_i        (rt_data_i),
    .hilo_i     (hilo),
    .op_ready_o (op_ready_o),
    .accept_o   (accept),
    .mul_lo_o   (mul_lo),
    .hilo_we_o  (mul_hilo_we),
    .hilo_o     (mul_hilo)
  );

  exu_hilo hilo_i (
    .clk        (clk),
    .reset_i    (reset_i),
    .accept_i   (accept),
    .op_i       (op_i),
    .a_i        (rs_data_i),
    .mul_we_i   (mul_hilo_we),
    .mul_hilo_i (mul_hilo),
    .hilo_o     (hilo)
  );

  exu_wb wb_i (
    .clk         (clk),
    .reset_i     (reset_i),
    .accept_i    (accept),
    .op_i        (op_i),
    .rd_addr_i   (rd_addr_i),
    .rd_we_i     (rd_we_i),
    .logic_res_i (logic_res),
    .arith_res_i (arith_res),
    .mul_lo_i    (mul_lo),
    .ovf_i       (arith_ovf),
    .hilo_i      (hilo),
    .wb_valid_o  (wb_valid_o),
    .wb_we_o     (wb_we_o),
    .wb_addr_o   (wb_addr_o),
    .wb_data_o   (wb_data_o),
    .ovf_o       (ovf_o)
  );

  assign hi_o = hilo.hl.hi;
  assign lo_o = hilo.hl.lo;

endmodule

`default_nettype wire

/* exu_wb.sv */
//**********************************************************************
// result select by operation class and the registered writeback stage
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module exu_wb
  import exu_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              reset_i,
  input  wire logic              accept_i,
  input  wire logic [OP_W-1:0]   op_i,
  input  wire logic [REG_AW-1:0] rd_addr_i,
  input  wire logic              rd_we_i,
  input  wire logic [XLEN-1:0]   logic_res_i,
  input  wire logic [XLEN-1:0]   arith_res_i,
  input  wire logic [XLEN-1:0]   mul_lo_i,
  input  wire logic              ovf_i,
  input  wire hilo_u             hilo_i,
  output logic                   wb_valid_o,
  output logic                   wb_we_o,
  output logic      [REG_AW-1:0] wb_addr_o,
  output logic      [XLEN-1:0]   wb_data_o,
  output logic                   ovf_o
);

  op_class_e       cls;
  logic [XLEN-1:0] res;

  assign cls = op_class(op_i);

  always_comb
  begin
    case (cls)
      CLS_LOGIC, CLS_SHIFT:
        res = logic_res_i;
      CLS_ARITH:
        res = arith_res_i;
      CLS_MUL:
        res = mul_lo_i;
      CLS_MOVE:
        res = (op_i == OP_MFHI) ? hilo_i.hl.hi : hilo_i.hl.lo;
      default:
        res = '0;
    endcase
  end

  // control
  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      wb_valid_o <= 1'b0;
      wb_we_o    <= 1'b0;
      ovf_o      <= 1'b0;
    end
    else
    begin
      wb_valid_o <= accept_i;
      // overflowing add/sub must not reach the register file
      wb_we_o    <= accept_i && rd_we_i && !ovf_i;
      ovf_o      <= accept_i && ovf_i;
    end
  end

  // payload
  always_ff @(posedge clk)
  begin
    if (accept_i)
    begin
      wb_addr_o <= rd_addr_i;
      wb_data_o <= res;
    end
  end

endmodule

`default_nettype wire

/* tb_exu.sv */
//**********************************************************************
// testbench for the execute unit, drives ops on the falling edge and
// checks each writeback and hi/lo against a reference model
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_exu
  import exu_pkg::*;
;

  localparam int READY_TMO = 20;
  localparam int DRAIN_TMO = 50;

  typedef struct packed {
    logic [XLEN-1:0]   data;
    logic              has_data;
    logic              ovf;
    logic              we;
    logic [REG_AW-1:0] addr;
    logic [63:0]       hilo;
    logic              late;
  } exp_t;

  logic              clk = 1'b0;
  logic              reset_i;
  logic              op_valid_i;
  logic [OP_W-1:0]   op_i;
  logic [XLEN-1:0]   rs_data_i;
  logic [XLEN-1:0]   rt_data_i;
  logic [REG_AW-1:0] rd_addr_i;
  logic              rd_we_i;
  logic              op_ready_o;
  logic              wb_valid_o;
  logic              wb_we_o;
  logic [REG_AW-1:0] wb_addr_o;
  logic [XLEN-1:0]   wb_data_o;
  logic              ovf_o;
  logic [XLEN-1:0]   hi_o;
  logic [XLEN-1:0]   lo_o;

  int          seed = 78788;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic [63:0] model_hilo;
  exp_t        exp_q[$];
  exp_t        cur;
  logic        hilo_pend = 1'b0;
  logic [63:0] pend_hilo;

  logic [OP_W-1:0] logic_ops [7] = '{OP_OR, OP_AND, OP_XOR, OP_NOR, OP_SLL, OP_SRL, OP_SRA};
  logic [OP_W-1:0] arith_ops [8] = '{OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
                                     OP_SLT, OP_SLTU, OP_CLZ, OP_CLO};
  logic [OP_W-1:0] mul_ops [3]   = '{OP_MULT, OP_MULTU, OP_MUL};
  logic [OP_W-1:0] acc_ops [4]   = '{OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
  logic [XLEN-1:0] edge_vals [5] = '{32'h0, 32'hffffffff, 32'h80000000, 32'h7fffffff, 32'h1};

  exu_top dut_i (
    .clk        (clk),
    .reset_i    (reset_i),
    .op_valid_i (op_valid_i),
    .op_i       (op_i),
    .rs_data_i  (rs_data_i),
    .rt_data_i  (rt_data_i),
    .rd_addr_i  (rd_addr_i),
    .rd_we_i    (rd_we_i),
    .op_ready_o (op_ready_o),
    .wb_valid_o (wb_valid_o),
    .wb_we_o    (wb_we_o),
    .wb_addr_o  (wb_addr_o),
    .wb_data_o  (wb_data_o),
    .ovf_o      (ovf_o),
    .hi_o       (hi_o),
    .lo_o       (lo_o)
  );

  always #4 clk = ~clk;

  //********************************************************************
  // reference model
  //********************************************************************
  function automatic void exp_result(
    input  logic [OP_W-1:0] op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  logic [63:0]     hl,
    output logic [XLEN-1:0] data,
    output logic            ovf,
    output logic [63:0]     hl_next,
    output logic            has_data
  );
    logic [32:0] sum;
    logic [32:0] diff;
    logic [63:0] sprod;
    logic [63:0] uprod;
    int          lead;
    sum   = {a[31], a} + {b[31], b};
    diff  = {a[31], a} - {b[31], b};
    sprod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    uprod = {32'h0, a} * {32'h0, b};
    // leading bits equal to 1 for clo, 0 for clz
    lead = 0;
    while ((lead < 32) && (a[31 - lead] == (op == OP_CLO)))
      lead++;
    data    = '0;
    hl_next = hl;
    case (op)
      OP_OR:            data = a | b;
      OP_AND:           data = a & b;
      OP_XOR:           data = a ^ b;
      OP_NOR:           data = ~(a | b);
      OP_SLL:           data = b << a[4:0];
      OP_SRL:           data = b >> a[4:0];
      OP_SRA:           data = $signed(b) >>> a[4:0];
      OP_ADD, OP_ADDU:  data = sum[31:0];
      OP_SUB, OP_SUBU:  data = diff[31:0];
      OP_SLT:           data = {31'h0, ($signed(a) < $signed(b))};
      OP_SLTU:          data = {31'h0, (a < b)};
      OP_CLZ, OP_CLO:   data = 32'(lead);
      OP_MULT:          hl_next = sprod;
      OP_MULTU:         hl_next = uprod;
      OP_MUL:
      begin
        data    = sprod[31:0];
        hl_next = sprod;
      end
      OP_MADD:          hl_next = hl + sprod;
      OP_MADDU:         hl_next = hl + uprod;
      OP_MSUB:          hl_next = hl - sprod;
      OP_MSUBU:         hl_next = hl - uprod;
      OP_MFHI:          data = hl[63:32];
      OP_MFLO:          data = hl[31:0];
      OP_MTHI:          hl_next = {a, hl[31:0]};
      OP_MTLO:          hl_next = {hl[63:32], a};
      default:          data = '0;
    endcase
    // signed overflow when the sign of the 33-bit result disagrees
    ovf = ((op == OP_ADD) && (sum[32] != sum[31])) ||
          ((op == OP_SUB) && (diff[32] != diff[31]));
    has_data = !(op inside {OP_MULT, OP_MULTU, OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU,
                            OP_MTHI, OP_MTLO});
  endfunction

  function automatic logic [XLEN-1:0] rand_word();
    rand_word = $random(seed);
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $finish;
  endtask

  //********************************************************************
  // driver side
  //********************************************************************
  task automatic issue_op(input logic [OP_W-1:0] op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, input logic [REG_AW-1:0] rd,
                          input logic we);
    exp_t            e;
    logic [XLEN-1:0] data;
    logic            ovf;
    logic [63:0]     hl_next;
    logic            has_data;
    int              n;
    n = 0;
    while (!op_ready_o)
    begin
      if (n >= READY_TMO)
        abort_run("timeout waiting for op_ready_o before issuing an operation");
      @(negedge clk);
      n++;
    end
    exp_result(op, a, b, model_hilo, data, ovf, hl_next, has_data);
    e.data     = data;
    e.has_data = has_data;
    e.ovf      = ovf;
    e.we       = we && !ovf;
    e.addr     = rd;
    e.hilo     = hl_next;
    e.late     = op inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    model_hilo = hl_next;
    exp_q.push_back(e);
    op_valid_i = 1'b1;
    op_i       = op;
    rs_data_i  = a;
    rt_data_i  = b;
    rd_addr_i  = rd;
    rd_we_i    = we;
    // ready was high, so the next rising edge accepts
    @(negedge clk);
    op_valid_i = 1'b0;
    if (e.late)
    begin
      check("op_ready_o", {63'h0, op_ready_o}, 64'h0);
      @(negedge clk);
      check("op_ready_o", {63'h0, op_ready_o}, 64'h1);
    end
  endtask

  task automatic drain_and_report(input string name, input int start);
    int n;
    n = 0;
    while ((exp_q.size() != 0) || hilo_pend)
    begin
      if (n >= DRAIN_TMO)
        abort_run("timeout waiting for outstanding writebacks");
      @(negedge clk);
      n++;
    end
    tests_run++;
    if (errors != start)
      tests_failed++;
    $display("test %s: %0d errors", name, errors - start);
  endtask

  //********************************************************************
  // compare process, one writeback per accepted op
  //********************************************************************
  always @(negedge clk)
  begin
    // accumulate result lands one cycle after its writeback
    if (hilo_pend)
    begin
      check("hi_o/lo_o", {hi_o, lo_o}, pend_hilo);
      hilo_pend = 1'b0;
    end
    if (!reset_i && wb_valid_o)
    begin
      if (exp_q.size() == 0)
      begin
        $display("writeback seen with no operation outstanding");
        errors++;
      end
      else
      begin
        cur = exp_q.pop_front();
        check("wb_addr_o", {59'h0, wb_addr_o}, {59'h0, cur.addr});
        check("wb_we_o", {63'h0, wb_we_o}, {63'h0, cur.we});
        check("ovf_o", {63'h0, ovf_o}, {63'h0, cur.ovf});
        if (cur.has_data)
          check("wb_data_o", {32'h0, wb_data_o}, {32'h0, cur.data});
        if (cur.late)
        begin
          hilo_pend = 1'b1;
          pend_hilo = cur.hilo;
        end
        else
          check("hi_o/lo_o", {hi_o, lo_o}, cur.hilo);
      end
    end
  end

  initial
  begin
    int              start;
    logic [XLEN-1:0] w;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    reset_i    = 1'b1;
    op_valid_i = 1'b0;
    op_i       = OP_OR;
    rs_data_i  = '0;
    rt_data_i  = '0;
    rd_addr_i  = '0;
    rd_we_i    = 1'b0;
    model_hilo = '0;
    repeat (3) @(negedge clk);
    reset_i = 1'b0;
    @(negedge clk);

    // state right after reset
    start = errors;
    check("wb_valid_o", {63'h0, wb_valid_o}, 64'h0);
    check("wb_we_o", {63'h0, wb_we_o}, 64'h0);
    check("ovf_o", {63'h0, ovf_o}, 64'h0);
    check("hi_o/lo_o", {hi_o, lo_o}, 64'h0);
    check("op_ready_o", {63'h0, op_ready_o}, 64'h1);
    drain_and_report("reset", start);

    start = errors;
    for (int i = 0; i < 28; i++)
    begin
      w = rand_word();
      issue_op(logic_ops[i % 7], rand_word(), rand_word(), w[4:0], w[5]);
    end
    drain_and_report("logic_shift", start);

    start = errors;
    for (int i = 0; i < 8; i++)
    begin
      for (int j = 0; j < 25; j++)
        issue_op(arith_ops[i], edge_vals[j / 5], edge_vals[j % 5], 5'(j), 1'b1);
      for (int j = 0; j < 6; j++)
        issue_op(arith_ops[i], rand_word(), rand_word(), 5'(j), 1'b1);
    end
    drain_and_report("arith", start);

    start = errors;
    for (int i = 0; i < 24; i++)
    begin
      a = (i < 15) ? edge_vals[i % 5] : rand_word();
      b = (i < 15) ? edge_vals[(i / 5 + i) % 5] : rand_word();
      issue_op(mul_ops[i % 3], a, b, 5'(i), 1'b1);
    end
    drain_and_report("multiply", start);

    // seed hi/lo, then accumulate ops back to back
    start = errors;
    issue_op(OP_MTHI, rand_word(), '0, '0, 1'b0);
    issue_op(OP_MTLO, rand_word(), '0, '0, 1'b0);
    for (int i = 0; i < 16; i++)
      issue_op(acc_ops[i % 4], rand_word(), rand_word(), 5'(i), 1'b1);
    drain_and_report("mul_accumulate", start);

    start = errors;
    for (int i = 0; i < 6; i++)
    begin
      issue_op(OP_MTHI, rand_word(), '0, '0, 1'b0);
      issue_op(OP_MFHI, '0, '0, 5'(i), 1'b1);
      issue_op(OP_MTLO, rand_word(), '0, '0, 1'b0);
      issue_op(OP_MFLO, '0, '0, 5'(i + 8), 1'b1);
    end
    drain_and_report("hilo_moves", start);

    $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
exu_pkg.sv
exu_logic_shift.sv
exu_arith.sv
exu_mul.sv
exu_hilo.sv
exu_wb.sv
exu_top.sv
exu_sva.sv
tb_exu.sv
